// ==== src/cvtPkg.sv ====
////////////////////////////////////////
// cvtPkg
// shared widths, float constants, stage payloads
// and the float word views of the integer-to-float unit
////////////////////////////////////////

package cvtPkg;

  ////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////

  // every integer is widened to this before conversion
  localparam int MagWidth = 32;
  // leading-zero count, 0..32
  localparam int ShiftBits = 6;
  // single precision exponent bias
  localparam int ExpBias = 127;
  // stored fraction bits, hidden one not counted
  localparam int FracBits = 23;

  ////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////

  // capture stage output, sign and absolute value
  typedef struct packed {
    logic                sign;
    logic [MagWidth-1:0] mag;
  } magWord_t;

  // normalize stage output, leading one sits at sig msb
  typedef struct packed {
    logic                sign;
    logic                isZero;
    logic [7:0]          exp;
    logic [MagWidth-1:0] sig;
  } normWord_t;

  // ieee-754 single, field view
  typedef struct packed {
    logic                sign;
    logic [7:0]          exp;
    logic [FracBits-1:0] frac;
  } floatFields_t;

  // one float word, seen either as a raw bus word or as fields
  typedef union packed {
    logic [31:0]  raw;
    floatFields_t fields;
  } float_u;

endpackage

// ==== src/lzc.sv ====
////////////////////////////////////////
// lzc
// leading-zero counter built as a recursive
// binary tree, with an all-zeros flag
////////////////////////////////////////

`timescale 1ns/10ps

module lzc #(parameter WIDTH = 1) (
  input  logic [WIDTH-1:0]           num,      // value to scan from the msb
  output logic [$clog2(WIDTH+1)-1:0] ZeroCnt,  // leading zeros found
  output logic                       AllZeros  // no bit set at all
);

  localparam int CntBits = $clog2(WIDTH+1);

  if (WIDTH == 1) begin : gLeaf
    // single bit, count is simply its inverse
    assign ZeroCnt  = ~num;
    assign AllZeros = ~num;
  end else begin : gSplit
    // upper part is the largest power of two below WIDTH
    localparam int UpWidth  = 2**($clog2(WIDTH)-1);
    localparam int LowWidth = WIDTH - UpWidth;

    logic [$clog2(UpWidth+1)-1:0]  upCnt;
    logic [$clog2(LowWidth+1)-1:0] lowCnt;
    logic                          upZero;
    logic                          lowZero;

    lzc #(.WIDTH(UpWidth)) upperLzc (
      .num(num[WIDTH-1 -: UpWidth]), .ZeroCnt(upCnt), .AllZeros(upZero));
    lzc #(.WIDTH(LowWidth)) lowerLzc (
      .num(num[LowWidth-1:0]), .ZeroCnt(lowCnt), .AllZeros(lowZero));

    // empty upper half passes the search on to the lower half
    assign ZeroCnt  = upZero ? CntBits'(UpWidth) + CntBits'(lowCnt) : CntBits'(upCnt);
    assign AllZeros = upZero & lowZero;
  end

endmodule

// ==== src/intCapture.sv ====
////////////////////////////////////////
// intCapture
// input stage, registers a request and splits
// the integer into sign and magnitude
////////////////////////////////////////

`timescale 1ns/10ps

module intCapture #(parameter WIDTH = 32) (
  input  logic                 clk,
  input  logic                 reset,
  // request side
  input  logic                 inValid,
  output logic                 inReady,
  input  logic [WIDTH-1:0]     inData,
  input  logic                 inSigned,
  // towards the normalize stage
  output logic                 magValid,
  input  logic                 magReady,
  output cvtPkg::magWord_t     magOut
);

  localparam int MagW = cvtPkg::MagWidth;

  logic            isNeg;
  logic [MagW-1:0] signExt;
  logic [MagW-1:0] zeroExt;
  cvtPkg::magWord_t nextWord;

  ////////////////////////////////////////
  // sign and magnitude
  ////////////////////////////////////////

  always_comb begin
    // negative only when the request asks for signed and msb is set
    isNeg   = inSigned & inData[WIDTH-1];
    signExt = MagW'($signed(inData));
    zeroExt = MagW'(inData);
    nextWord.sign = isNeg;
    // most negative input wraps to 2^(WIDTH-1), which is the true magnitude
    nextWord.mag  = isNeg ? -signExt : zeroExt;
  end

  ////////////////////////////////////////
  // stage slot
  ////////////////////////////////////////

  // slot is free when empty or when it drains this cycle
  assign inReady = ~magValid | magReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      magValid <= 1'b0;
    end else if (inReady) begin
      magValid <= inValid;
    end
  end

  // payload only moves on a transfer, so it holds while stalled
  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      magOut <= nextWord;
    end
  end

endmodule

// ==== src/normShift.sv ====
////////////////////////////////////////
// normShift
// middle stage, counts leading zeros, shifts the
// leading one to the msb and forms the biased exponent
////////////////////////////////////////

`timescale 1ns/10ps

module normShift (
  input  logic              clk,
  input  logic              reset,
  // from the capture stage
  input  logic              magValid,
  output logic              magReady,
  input  cvtPkg::magWord_t  magIn,
  // towards the round stage
  output logic              normValid,
  input  logic              normReady,
  output cvtPkg::normWord_t normOut
);

  logic [cvtPkg::ShiftBits-1:0] zeroCnt;
  logic                         magZero;
  cvtPkg::normWord_t            nextWord;

  // count over the full internal width
  lzc #(.WIDTH(cvtPkg::MagWidth)) magLzc (
    .num(magIn.mag),
    .ZeroCnt(zeroCnt),
    .AllZeros(magZero)
  );

  ////////////////////////////////////////
  // normalize
  ////////////////////////////////////////

  always_comb begin
    nextWord.sign   = magIn.sign;
    nextWord.isZero = magZero;
    // value is 1.sig * 2^(MagWidth-1-cnt)
    nextWord.exp    = 8'(cvtPkg::ExpBias + cvtPkg::MagWidth - 1) - 8'(zeroCnt);
    // shift of 32 on a zero word just yields zero
    nextWord.sig    = magIn.mag << zeroCnt;
  end

  ////////////////////////////////////////
  // stage slot
  ////////////////////////////////////////

  assign magReady = ~normValid | normReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      normValid <= 1'b0;
    end else if (magReady) begin
      normValid <= magValid;
    end
  end

  always_ff @(posedge clk) begin
    if (magValid && magReady) begin
      normOut <= nextWord;
    end
  end

endmodule

// ==== src/roundPack.sv ====
////////////////////////////////////////
// roundPack
// output stage, rounds the normalized significand
// to nearest even and packs a single precision word
////////////////////////////////////////

`timescale 1ns/10ps

module roundPack (
  input  logic              clk,
  input  logic              reset,
  // from the normalize stage
  input  logic              normValid,
  output logic              normReady,
  input  cvtPkg::normWord_t normIn,
  // result side
  output logic              outValid,
  input  logic              outReady,
  output logic [31:0]       outData
);

  // kept significand includes the hidden one
  localparam int KeepBits = cvtPkg::FracBits + 1;
  // bit just below the kept part
  localparam int GuardPos = cvtPkg::MagWidth - KeepBits - 1;

  logic [KeepBits-1:0] kept;
  logic                guard;
  logic                sticky;
  logic                roundUp;
  logic [KeepBits:0]   rounded;
  logic                carry;
  cvtPkg::float_u      nextFloat;
  cvtPkg::float_u      outReg;

  ////////////////////////////////////////
  // round to nearest even
  ////////////////////////////////////////

  always_comb begin
    kept   = normIn.sig[cvtPkg::MagWidth-1 -: KeepBits];
    guard  = normIn.sig[GuardPos];
    sticky = |normIn.sig[GuardPos-1:0];
    // above half, or exactly half with an odd lsb
    roundUp = guard & (sticky | kept[0]);
    rounded = {1'b0, kept} + {{KeepBits{1'b0}}, roundUp};
    // all ones rounded up, value becomes the next power of two
    carry   = rounded[KeepBits];
  end

  ////////////////////////////////////////
  // pack
  ////////////////////////////////////////

  always_comb begin
    if (normIn.isZero) begin
      // zero always packs as +0.0
      nextFloat.fields.sign = 1'b0;
      nextFloat.fields.exp  = 8'd0;
      nextFloat.fields.frac = '0;
    end else begin
      nextFloat.fields.sign = normIn.sign;
      nextFloat.fields.exp  = normIn.exp + {7'd0, carry};
      // on a carry the low bits of the sum are already zero
      nextFloat.fields.frac = rounded[cvtPkg::FracBits-1:0];
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  assign normReady = ~outValid | outReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
    end else if (normReady) begin
      outValid <= normValid;
    end
  end

  always_ff @(posedge clk) begin
    if (normValid && normReady) begin
      outReg <= nextFloat;
    end
  end

  assign outData = outReg.raw;

endmodule

// ==== src/intToFloat.sv ====
////////////////////////////////////////
// intToFloat
// three stage integer to single precision
// converter with valid/ready on both sides
////////////////////////////////////////

`timescale 1ns/10ps

module intToFloat #(parameter WIDTH = 32) (
  input  logic             clk,
  input  logic             reset,
  // integer requests
  input  logic             inValid,
  output logic             inReady,
  input  logic [WIDTH-1:0] inData,
  input  logic             inSigned,
  // float results
  output logic             outValid,
  input  logic             outReady,
  output logic [31:0]      outData
);

  // capture to normalize
  logic              magValid;
  logic              magReady;
  cvtPkg::magWord_t  magWord;

  // normalize to round
  logic              normValid;
  logic              normReady;
  cvtPkg::normWord_t normWord;

  intCapture #(.WIDTH(WIDTH)) captureStage (
    .clk(clk), .reset(reset),
    .inValid(inValid), .inReady(inReady), .inData(inData), .inSigned(inSigned),
    .magValid(magValid), .magReady(magReady), .magOut(magWord)
  );

  normShift normStage (
    .clk(clk), .reset(reset),
    .magValid(magValid), .magReady(magReady), .magIn(magWord),
    .normValid(normValid), .normReady(normReady), .normOut(normWord)
  );

  roundPack roundStage (
    .clk(clk), .reset(reset),
    .normValid(normValid), .normReady(normReady), .normIn(normWord),
    .outValid(outValid), .outReady(outReady), .outData(outData)
  );

endmodule

// ==== tb/intToFloat_checker.sv ====
////////////////////////////////////////
// intToFloat_checker
// handshake assertions bound to the top level
////////////////////////////////////////

`timescale 1ns/10ps

module intToFloat_checker (
  input logic        clk,
  input logic        reset,
  input logic        inReady,
  input logic        outValid,
  input logic        outReady,
  input logic [31:0] outData
);

  // every slot empties on reset
  resetEmpty: assert property (@(posedge clk) reset |=> !outValid)
    else $error("outValid high in the cycle after reset");

  // a stalled result holds until taken
  stallStable: assert property (@(posedge clk) disable iff (reset)
    (outValid && !outReady) |=> (outValid && $stable(outData)))
    else $error("outValid or outData changed while outReady was low");

  // a free output keeps the input side open
  readyFlow: assert property (@(posedge clk) disable iff (reset)
    (outReady && $past(outReady) && $past(outReady, 2)) |-> inReady)
    else $error("inReady low although outReady was high for three cycles");

endmodule

bind intToFloat intToFloat_checker handshakeChecker (
  .clk(clk), .reset(reset), .inReady(inReady),
  .outValid(outValid), .outReady(outReady), .outData(outData)
);

// ==== tb/intToFloat_tb.sv ====
////////////////////////////////////////
// intToFloat_tb
// drives the integer-to-float unit with directed,
// random and back-pressure traffic and compares
// each result against a reference model
////////////////////////////////////////

`timescale 1ns/10ps

module intToFloat_tb;

  localparam int ClkPeriod    = 4;
  // 7 directed, 2 x 300 random, 3 stall items
  localparam int Transactions = 610;
  localparam int LimitCycles  = Transactions * 20 + 200;

  logic        clk;
  logic        reset;
  logic        inValid;
  logic        inReady;
  logic [31:0] inData;
  logic        inSigned;
  logic        outValid;
  logic        outReady;
  logic [31:0] outData;

  logic [31:0] expQ[$];
  int          acceptQ[$];
  logic [31:0] dataSeed = 32'd65402;
  logic [31:0] readySeed = ~32'd65402;
  // 0 ready high, 1 random ready, 2 ready low
  int          readyMode = 0;
  bit          checkLatency = 0;
  int          cycle = 0;
  int          errors = 0;
  int          errStart = 0;
  int          sent = 0;
  int          checked = 0;

  intToFloat #(.WIDTH(32)) intToFloat_inst (
    .clk(clk), .reset(reset),
    .inValid(inValid), .inReady(inReady), .inData(inData), .inSigned(inSigned),
    .outValid(outValid), .outReady(outReady), .outData(outData)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected float from integer and signed flag
  function automatic logic [31:0] refFloat(input logic [31:0] val, input logic sgn);
    logic        neg;
    logic [31:0] mag;
    logic [31:0] keep;
    logic [7:0]  e;
    logic        guard;
    logic        sticky;
    int          hb;
    neg = sgn & val[31];
    mag = neg ? (~val + 32'd1) : val;
    if (mag == 32'd0) begin
      return 32'd0;
    end
    hb = 0;
    // highest set bit gives the unbiased exponent
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) hb = i;
    end
    e = 8'(127 + hb);
    guard = 1'b0;
    sticky = 1'b0;
    if (hb <= 23) begin
      keep = mag << (23 - hb);
    end else begin
      keep = mag >> (hb - 23);
      guard = mag[hb-24];
      sticky = (mag & ((32'd1 << (hb - 24)) - 32'd1)) != 32'd0;
    end
    if (guard && (sticky || keep[0])) keep = keep + 32'd1;
    // rounding overflowed into bit 24
    if (keep[24]) begin
      e = e + 8'd1;
      keep = keep >> 1;
    end
    return {neg, e, keep[22:0]};
  endfunction

  task automatic driveReady();
    if (readyMode == 1) begin
      readySeed = xorshift(readySeed);
      outReady = readySeed[7];
    end else begin
      outReady = (readyMode == 0);
    end
  endtask

  // called at posedge + 1, returns at posedge + 1 after the transfer
  task automatic sendItem(input logic [31:0] data, input logic sgn);
    inValid = 1'b1;
    inData = data;
    inSigned = sgn;
    driveReady();
    @(negedge clk);
    while (!inReady) begin
      @(posedge clk);
      #1;
      driveReady();
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    inValid = 1'b0;
    sent++;
  endtask

  task automatic sendRandom();
    logic [31:0] r;
    dataSeed = xorshift(dataSeed);
    r = dataSeed;
    dataSeed = xorshift(dataSeed);
    // varied shift so small magnitudes show up too
    sendItem(r >> dataSeed[5:1], dataSeed[0]);
  endtask

  task automatic waitDrain();
    outReady = 1'b1;
    while (expQ.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic reportTest(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - errStart);
    errStart = errors;
  endtask

  ////////////////////////////////////////
  // scoreboard, sampled mid-cycle
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      if (outValid && outReady) begin
        if (expQ.size() == 0) begin
          $display("output transfer with no input outstanding");
          errors++;
        end else begin
          assert (outData === expQ[0]) else begin
            $display("error outData: expected %08h actual %08h", expQ[0], outData);
            errors++;
          end
          if (checkLatency) begin
            assert (cycle - acceptQ[0] == 3) else begin
              $display("result came %0d cycles after acceptance", cycle - acceptQ[0]);
              errors++;
            end
          end
          void'(expQ.pop_front());
          void'(acceptQ.pop_front());
          checked++;
        end
      end
      if (inValid && inReady) begin
        expQ.push_back(refFloat(inData, inSigned));
        acceptQ.push_back(cycle);
      end
    end
    cycle++;
  end

  initial begin
    #(LimitCycles * ClkPeriod);
    $display("timeout, the unit stopped delivering results");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    reset = 1'b1;
    inValid = 1'b0;
    inData = 32'd0;
    inSigned = 1'b0;
    outReady = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    assert (!outValid && inReady) else begin
      $display("after reset outValid is not low or inReady is not high");
      errors++;
    end
    reportTest(1, "reset state");
    @(posedge clk);
    #1;
    sendItem(32'h0000_0000, 1'b0);
    sendItem(32'h0000_0001, 1'b0);
    sendItem(32'h0100_0001, 1'b0);
    sendItem(32'h0100_0003, 1'b0);
    sendItem(32'hFFFF_FFFF, 1'b0);
    sendItem(32'hFFFF_FFFF, 1'b1);
    sendItem(32'h8000_0000, 1'b1);
    waitDrain();
    reportTest(2, "directed values");
    checkLatency = 1'b1;
    repeat (300) sendRandom();
    waitDrain();
    checkLatency = 1'b0;
    reportTest(3, "random, ready high");
    readyMode = 1;
    repeat (300) sendRandom();
    readyMode = 0;
    waitDrain();
    reportTest(4, "random, random ready");
    // fill all three slots while the output is blocked
    readyMode = 2;
    repeat (3) sendRandom();
    repeat (4) @(negedge clk);
    assert (!inReady && outValid) else begin
      $display("all slots full but inReady stayed high");
      errors++;
    end
    readyMode = 0;
    @(posedge clk);
    #1;
    waitDrain();
    // a duplicated result would still be pending here
    repeat (3) @(negedge clk);
    assert (!outValid) else begin
      $display("extra result appeared after all %0d sent items were received", sent);
      errors++;
    end
    reportTest(5, "back-pressure");
    $display("results checked %0d, errors %0d", checked, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/cvtPkg.sv
src/lzc.sv
src/intCapture.sv
src/normShift.sv
src/roundPack.sv
src/intToFloat.sv
tb/intToFloat_checker.sv
tb/intToFloat_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = intToFloat_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
